/* Bender.yml */
package:
  name: txq_queue

sources:
  - include_dirs:
      - .
    files:
      - txq_pkg.sv
      - txq_if.sv
      - txq_packer.sv
      - txq_ctrl.sv
      - txq_bank.sv
      - txq_read_mux.sv
      - txq_framer.sv
      - txq_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_txq_top.sv

/* project.f */
+incdir+.
txq_pkg.sv
txq_if.sv
txq_packer.sv
txq_ctrl.sv
txq_bank.sv
txq_read_mux.sv
txq_framer.sv
txq_top.sv
tb_txq_top.sv

/* tb_txq_top.sv */
/*
 * Testbench for the transmit antenna queue. Drives LFSR elements on
 * the falling edge, builds the expected output words per written block
 * and checks data, metadata, framing, package info and o_tready.
 * Run with the sources of project.f and tb_txq_top as the top module.
 */
`timescale 1ns/1ps
`default_nettype none

`include "txq_defines.svh"

module tb_txq_top;

    localparam int DEPTH       = `TXQ_BLOCK_DEPTH;
    localparam int RE_PER_PKT  = `TXQ_RE_PER_RB * `TXQ_RB_PER_PKT;
    localparam int RESET_CYC   = 16;
    localparam int BLK_RANDOM  = 3;
    localparam int BLK_FULL    = 15;
    localparam int TIMEOUT_CYC = (BLK_RANDOM + BLK_FULL) * (4 * DEPTH + 20) + RESET_CYC;
    // Expected word is {data 128, agc 32, meta 20}
    localparam int EXP_W       = 180;

    logic                          i_clk;
    logic                          i_reset;
    logic [`TXQ_NUM_ANT-1:0][31:0] i_ant_data;
    logic [`TXQ_NUM_ANT-1:0][7:0]  i_fft_agc;
    logic                          i_rx_vld;
    logic [3:0]                    i_lane_idx;
    logic [3:0]                    i_rbg_idx;
    logic [3:0]                    i_pkg_type;
    logic                          i_cell_idx;
    logic [6:0]                    i_slot_idx;
    logic [3:0]                    i_symb_idx;
    logic [`TXQ_GRP_ANT-1:0][31:0] o_tx_data;
    logic                          o_tx_vld;
    logic                          o_tx_sop;
    logic                          o_tx_eop;
    logic                          o_tready;
    logic [8:0]                    o_prb_idx;
    logic [`TXQ_GRP_ANT-1:0][7:0]  o_pkg_info;
    logic [2:0]                    o_lane_idx;
    logic [31:0]                   o_fft_agc;
    logic [3:0]                    o_rbg_idx;
    logic [3:0]                    o_pkg_type;
    logic                          o_cell_idx;
    logic [6:0]                    o_slot_idx;
    logic [3:0]                    o_symb_idx;

    logic [31:0]      lfsr;
    logic [EXP_W-1:0] exp_q [$];
    logic [EXP_W-1:0] exp_word;
    logic [255:0]     blk_ant [DEPTH];
    logic [63:0]      blk_agc [DEPTH];
    logic [19:0]      blk_meta [DEPTH];
    logic [8:0]       prb_model;
    logic [3:0]       lane_pick;
    logic             grp;
    int               wr_idx;
    int               blocks_written;
    int               blocks_rcvd;
    int               beat_cnt;
    int               cycle_cnt;
    int               total_chk;
    int               total_err;
    int               chk_cnt [1:6];
    int               err_cnt [1:6];
    string            test_name [1:6];
    bit               saw_not_ready;
    bit               saw_recover;

    txq_top txq_top_inst (.*);

    always #20 i_clk = ~i_clk;

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Byte k holds the group number high and the antenna number low
    function automatic logic [31:0] pkg_info_for(input logic [3:0] lane, input logic g);
        logic [31:0] info;
        for (int k = 0; k < `TXQ_GRP_ANT; k++) begin
            info[8*k +: 8] = {4'((lane * 2 + g) % 16), 4'((lane * 8 + 2 * k + g) % 16)};
        end
        return info;
    endfunction

    task automatic report_failure(input int test_id, input string what);
        err_cnt[test_id]++;
        $display("t=%0t %s went wrong: %s", $time, test_name[test_id], what);
    endtask

    task automatic check_value(input int test_id, input string name,
                               input logic [EXP_W-1:0] got, input logic [EXP_W-1:0] exp);
        chk_cnt[test_id]++;
        assert (got === exp) else begin
            err_cnt[test_id]++;
            $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input int test_id, input logic cond, input string what);
        chk_cnt[test_id]++;
        assert (cond) else report_failure(test_id, what);
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic queue_block();
        logic [EXP_W-1:0] word;
        for (int g = 0; g < 2; g++) begin
            for (int a = 0; a < DEPTH; a++) begin
                word = '0;
                for (int k = 0; k < `TXQ_GRP_ANT; k++) begin
                    word[52 + 32*k +: 32] = blk_ant[a][32*(2*k+g) +: 32];
                    word[20 + 8*k +: 8]   = blk_agc[a][8*(2*k+g) +: 8];
                end
                word[19:0] = blk_meta[a];
                exp_q.push_back(word);
            end
        end
    endtask

    task automatic drive_element();
        for (int n = 0; n < `TXQ_NUM_ANT; n++) begin
            i_ant_data[n] = take_bits(32);
            i_fft_agc[n]  = take_bits(8);
        end
        i_rbg_idx  = take_bits(4);
        i_pkg_type = take_bits(4);
        i_cell_idx = take_bits(1);
        i_slot_idx = take_bits(7);
        i_symb_idx = take_bits(4);
        i_rx_vld   = 1'b1;
        blk_ant[wr_idx]  = i_ant_data;
        blk_agc[wr_idx]  = i_fft_agc;
        blk_meta[wr_idx] = {i_rbg_idx, i_pkg_type, i_cell_idx, i_slot_idx, i_symb_idx};
        wr_idx++;
        if (wr_idx == DEPTH) begin
            queue_block();
            wr_idx = 0;
            blocks_written++;
        end
    endtask

    // Strobes only while o_tready is high, every cycle when full_rate
    task automatic write_blocks(input int nblk, input bit full_rate);
        int sent;
        bit go;
        sent = 0;
        while (sent < nblk * DEPTH) begin
            @(negedge i_clk);
            if (full_rate && !o_tready) begin
                saw_not_ready = 1'b1;
            end else if (full_rate && saw_not_ready) begin
                saw_recover = 1'b1;
            end
            go = o_tready && (full_rate || (take_bits(1) != 0));
            if (go) begin
                drive_element();
                sent++;
            end else begin
                i_rx_vld = 1'b0;
            end
        end
        @(negedge i_clk);
        i_rx_vld = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || o_tx_vld) begin
            @(negedge i_clk);
        end
        repeat (4) @(negedge i_clk);
    endtask

    task automatic print_test(input int t);
        $display("Test %0d %s: %s, %0d checks, %0d errors", t, test_name[t],
                 (err_cnt[t] == 0) ? "ok" : "FAILED", chk_cnt[t], err_cnt[t]);
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------
    assert property (@(posedge i_clk) disable iff (i_reset) (o_tx_sop || o_tx_eop) |-> o_tx_vld)
        else report_failure(4, "sop or eop set without a valid beat");

    always @(posedge i_clk) begin
        if (!i_reset && o_tx_vld) begin
            if (exp_q.size() == 0) begin
                report_failure(6, "output beat with no written block left to match");
            end else begin
                exp_word = exp_q.pop_front();
                check_value(2, "o_tx_data", o_tx_data, exp_word[179:52]);
                check_value(3, "o_fft_agc", o_fft_agc, exp_word[51:20]);
                check_value(3, "o_rbg_idx..o_symb_idx", {o_rbg_idx, o_pkg_type, o_cell_idx,
                            o_slot_idx, o_symb_idx}, exp_word[19:0]);
            end
            check_value(4, "o_tx_eop", o_tx_eop, (beat_cnt % `TXQ_RE_PER_RB) == `TXQ_RE_PER_RB - 1);
            check_value(4, "o_tx_sop", o_tx_sop, (beat_cnt % RE_PER_PKT) == 0);
            check_value(4, "o_prb_idx", o_prb_idx, prb_model);
            grp = (beat_cnt % (2 * DEPTH)) >= DEPTH;
            check_value(5, "o_pkg_info", o_pkg_info, pkg_info_for(i_lane_idx, grp));
            check_value(5, "o_lane_idx", o_lane_idx, (i_lane_idx == 4'd0) ? 3'd0 : 3'd1);
            if ((beat_cnt % `TXQ_RE_PER_RB) == `TXQ_RE_PER_RB - 1) begin
                prb_model = (prb_model == `TXQ_PRB_NUM - 1) ? 9'd0 : prb_model + 9'd1;
            end
            beat_cnt++;
            if ((beat_cnt % (2 * DEPTH)) == 0) begin
                blocks_rcvd++;
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles, the queue did not drain", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        i_clk      = 1'b0;
        i_reset    = 1'b1;
        i_ant_data = '0;
        i_fft_agc  = '0;
        i_rx_vld   = 1'b0;
        i_lane_idx = 4'd0;
        i_rbg_idx  = 4'd0;
        i_pkg_type = 4'd0;
        i_cell_idx = 1'b0;
        i_slot_idx = 7'd0;
        i_symb_idx = 4'd0;
        lfsr       = 32'h1cea;
        prb_model  = 9'd0;
        wr_idx         = 0;
        blocks_written = 0;
        blocks_rcvd    = 0;
        beat_cnt       = 0;
        cycle_cnt      = 0;
        saw_not_ready  = 1'b0;
        saw_recover    = 1'b0;
        test_name[1] = "reset state";
        test_name[2] = "data order";
        test_name[3] = "metadata";
        test_name[4] = "framing";
        test_name[5] = "package info";
        test_name[6] = "ready and block count";
        for (int t = 1; t <= 6; t++) begin
            chk_cnt[t] = 0;
            err_cnt[t] = 0;
        end

        repeat (RESET_CYC) @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);
        check_value(1, "o_tx_vld", o_tx_vld, 1'b0);
        check_value(1, "o_tx_sop", o_tx_sop, 1'b0);
        check_value(1, "o_tx_eop", o_tx_eop, 1'b0);
        check_value(1, "o_tready", o_tready, 1'b1);
        check_value(1, "o_prb_idx", o_prb_idx, 9'd0);
        print_test(1);

        // Lane 0 at a random strobe rate, then a nonzero lane at full rate
        write_blocks(BLK_RANDOM, 1'b0);
        wait_drain();
        lane_pick = take_bits(4);
        i_lane_idx = (lane_pick == 4'd0) ? 4'd1 : lane_pick;
        write_blocks(BLK_FULL, 1'b1);
        wait_drain();

        check_true(6, saw_not_ready && saw_recover, "o_tready did not drop and recover");
        check_value(6, "blocks received", blocks_rcvd, blocks_written);
        total_chk = 0;
        total_err = 0;
        for (int t = 2; t <= 6; t++) begin
            print_test(t);
        end
        for (int t = 1; t <= 6; t++) begin
            total_chk += chk_cnt[t];
            total_err += err_cnt[t];
        end
        $display("Checks: %0d, errors: %0d", total_chk, total_err);
        if (total_err == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* txq_bank.sv */
/*
 * Ping-pong block memory for one antenna group. Two halves of
 * TXQ_BLOCK_DEPTH words with a registered read port. PAYLOAD_T picks
 * whether the bank stores sample words or metadata words, and i_grp
 * ties the instance to group 0 or group 1.
 */
`timescale 1ns/1ps
`default_nettype none

`include "txq_defines.svh"

module txq_bank
    import txq_pkg::*;
#(
    parameter type PAYLOAD_T = sample_t
) (
    input  wire    i_clk,
    txq_wr_if.bank wr,
    txq_rd_if.bank rd,
    input  wire    i_grp,
    output PAYLOAD_T o_rd_data
);

    PAYLOAD_T mem [2][`TXQ_BLOCK_DEPTH];
    PAYLOAD_T wr_data;

    // Sample words are the wide payload, metadata the narrow one
    if ($bits(PAYLOAD_T) == $bits(sample_t)) begin : gen_sample
        assign wr_data = i_grp ? wr.data1 : wr.data0;
    end else begin : gen_meta
        assign wr_data = i_grp ? wr.meta1 : wr.meta0;
    end

    always_ff @(posedge i_clk) begin
        if (wr.wen) begin
            mem[wr.half][wr.addr] <= wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd.ren && (rd.grp == i_grp)) begin
            o_rd_data <= mem[rd.half][rd.addr];
        end
    end

endmodule

`default_nettype wire

/* txq_ctrl.sv */
/*
 * Queue controller. Generates the write address and half, counts
 * complete blocks waiting for read-out (0 to 2), runs the read
 * sequence over group 0 then group 1 of the oldest half, and tells
 * the source when another strobe would overrun a half still in use.
 */
`timescale 1ns/1ps
`default_nettype none

`include "txq_defines.svh"

module txq_ctrl
    import txq_pkg::*;
(
    input  wire    i_clk,
    input  wire    i_reset,
    txq_wr_if.ctrl wr,
    txq_rd_if.ctrl rd,
    output logic   o_tready
);

    localparam waddr_t LAST_ADDR = waddr_t'(`TXQ_BLOCK_DEPTH - 1);

    waddr_t     wr_addr;
    logic       wr_half;
    logic       wr_last;
    logic [1:0] pend_cnt;
    logic       rd_busy;
    logic       rd_grp;
    logic       rd_half;
    waddr_t     rd_addr;
    logic       rd_last;

    // ------------------------------
    // Write addressing
    // ------------------------------
    assign wr_last = wr.wen && (wr_addr == LAST_ADDR);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_addr <= '0;
            wr_half <= 1'b0;
        end else if (wr.wen) begin
            if (wr_last) begin
                wr_addr <= '0;
                wr_half <= ~wr_half;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    assign wr.addr = wr_addr;
    assign wr.half = wr_half;

    // ------------------------------
    // Pending block count
    // ------------------------------
    assign rd_last = rd_busy && rd_grp && (rd_addr == LAST_ADDR);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pend_cnt <= 2'd0;
        end else if (wr_last && !rd_last) begin
            pend_cnt <= pend_cnt + 2'd1;
        end else if (!wr_last && rd_last) begin
            pend_cnt <= pend_cnt - 2'd1;
        end
    end

    // ------------------------------
    // Read sequencer
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_busy <= 1'b0;
            rd_grp  <= 1'b0;
            rd_half <= 1'b0;
            rd_addr <= '0;
        end else if (!rd_busy) begin
            rd_busy <= (pend_cnt != 2'd0);
        end else if (rd_addr == LAST_ADDR) begin
            rd_addr <= '0;
            if (rd_grp) begin
                rd_grp  <= 1'b0;
                rd_half <= ~rd_half;
                // Carry straight on when the next half is already full
                rd_busy <= (pend_cnt == 2'd2) || wr_last;
            end else begin
                rd_grp <= 1'b1;
            end
        end else begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    assign rd.ren  = rd_busy;
    assign rd.grp  = rd_grp;
    assign rd.addr = rd_addr;
    assign rd.half = rd_half;

    // Both halves taken, or about to be with the word in the packer
    assign o_tready = !((pend_cnt == 2'd2) || ((pend_cnt == 2'd1) && wr_last));

endmodule

`default_nettype wire

/* txq_defines.svh */
/*
 * Sizing and framing constants for the transmit antenna queue.
 * Include this in any file that needs block depth, antenna counts
 * or resource block framing limits.
 */
`ifndef TXQ_DEFINES_SVH
`define TXQ_DEFINES_SVH

// Words per ping-pong block in whole resource blocks of TXQ_RE_PER_RB
`define TXQ_BLOCK_DEPTH 48

// Antennas on the input and per output group
`define TXQ_NUM_ANT 8
`define TXQ_GRP_ANT 4

// Output framing
`define TXQ_RE_PER_RB 12
`define TXQ_RB_PER_PKT 4
`define TXQ_PRB_NUM 132

`endif

/* txq_framer.sv */
/*
 * Output framing. Counts elements within a resource block, resource
 * blocks within a packet and the running PRB index. sop and eop are
 * decoded from the counters in the same cycle as the valid beat.
 */
`timescale 1ns/1ps
`default_nettype none

`include "txq_defines.svh"

module txq_framer (
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire        i_vld,
    output logic       o_sop,
    output logic       o_eop,
    output logic [8:0] o_prb_idx
);

    localparam int RE_W = $clog2(`TXQ_RE_PER_RB);
    localparam int RB_W = $clog2(`TXQ_RB_PER_PKT);
    localparam logic [RE_W-1:0] RE_LAST  = RE_W'(`TXQ_RE_PER_RB - 1);
    localparam logic [RB_W-1:0] RB_LAST  = RB_W'(`TXQ_RB_PER_PKT - 1);
    localparam logic [8:0]      PRB_LAST = 9'(`TXQ_PRB_NUM - 1);

    logic [RE_W-1:0] re_cnt;
    logic [RB_W-1:0] rb_cnt;

    assign o_eop = i_vld && (re_cnt == RE_LAST);
    assign o_sop = i_vld && (re_cnt == '0) && (rb_cnt == '0);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt    <= '0;
            rb_cnt    <= '0;
            o_prb_idx <= '0;
        end else if (o_eop) begin
            re_cnt    <= '0;
            rb_cnt    <= (rb_cnt == RB_LAST) ? '0 : rb_cnt + 1'b1;
            o_prb_idx <= (o_prb_idx == PRB_LAST) ? '0 : o_prb_idx + 9'd1;
        end else if (i_vld) begin
            re_cnt <= re_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* txq_if.sv */
/*
 * Write and read side interfaces between the queue controller,
 * the packer, the block banks and the read-out stage.
 * Write side: one word per wen strobe at (half, addr).
 * Read side: a ren strobe returns the addressed group one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

interface txq_wr_if
    import txq_pkg::*;
();
    logic    wen;
    sample_t data0;
    sample_t data1;
    meta_t   meta0;
    meta_t   meta1;
    waddr_t  addr;
    logic    half;

    modport packer (output wen, data0, data1, meta0, meta1);
    modport ctrl   (input wen, output addr, half);
    modport bank   (input wen, data0, data1, meta0, meta1, addr, half);
endinterface

interface txq_rd_if
    import txq_pkg::*;
();
    logic   ren;
    logic   grp;
    waddr_t addr;
    logic   half;

    modport ctrl (output ren, grp, addr, half);
    modport bank (input ren, grp, addr, half);
    modport mux  (input ren, grp);
endinterface

`default_nettype wire

/* txq_packer.sv */
/*
 * Input register stage. Takes one resource element for all antennas
 * per strobe and splits it into the even group (0) and odd group (1),
 * each with its own metadata word. One cycle of latency.
 */
`timescale 1ns/1ps
`default_nettype none

`include "txq_defines.svh"

module txq_packer
    import txq_pkg::*;
(
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire                                i_rx_vld,
    input  wire [`TXQ_NUM_ANT-1:0][31:0]       i_ant_data,
    input  wire [`TXQ_NUM_ANT-1:0][7:0]        i_fft_agc,
    input  wire [3:0]                          i_rbg_idx,
    input  wire [3:0]                          i_pkg_type,
    input  wire                                i_cell_idx,
    input  wire [6:0]                          i_slot_idx,
    input  wire [3:0]                          i_symb_idx,
    txq_wr_if.packer                           wr
);

    meta_t meta_even;
    meta_t meta_odd;

    // Symbol fields are common, AGC bytes follow the antenna split
    always_comb begin
        meta_even.fft_agc  = '0;
        meta_even.rbg_idx  = i_rbg_idx;
        meta_even.pkg_type = i_pkg_type;
        meta_even.cell_idx = i_cell_idx;
        meta_even.slot_idx = i_slot_idx;
        meta_even.symb_idx = i_symb_idx;
        meta_odd           = meta_even;
        for (int k = 0; k < `TXQ_GRP_ANT; k++) begin
            meta_even.fft_agc[8*k +: 8] = i_fft_agc[2*k];
            meta_odd.fft_agc[8*k +: 8]  = i_fft_agc[2*k+1];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr.wen <= 1'b0;
        end else begin
            wr.wen <= i_rx_vld;
        end
    end

    always_ff @(posedge i_clk) begin
        for (int k = 0; k < `TXQ_GRP_ANT; k++) begin
            wr.data0[k] <= i_ant_data[2*k];
            wr.data1[k] <= i_ant_data[2*k+1];
        end
        wr.meta0 <= meta_even;
        wr.meta1 <= meta_odd;
    end

endmodule

`default_nettype wire

/* txq_pkg.sv */
/*
 * Shared types of the transmit antenna queue: one antenna group's
 * sample word, the per-symbol metadata word, the package-info bytes
 * and the block word address. Modules import it in their header.
 */
`default_nettype none

`include "txq_defines.svh"

package txq_pkg;

    // Lane k carries antenna 2k+g for group g
    typedef logic [`TXQ_GRP_ANT-1:0][31:0] sample_t;

    // The group's four AGC bytes sit in fft_agc with the low byte first
    typedef struct packed {
        logic [31:0] fft_agc;
        logic [3:0]  rbg_idx;
        logic [3:0]  pkg_type;
        logic        cell_idx;
        logic [6:0]  slot_idx;
        logic [3:0]  symb_idx;
    } meta_t;

    // Byte k describes output lane k
    typedef logic [`TXQ_GRP_ANT-1:0][7:0] pkg_info_t;

    // Word address inside one block half
    typedef logic [$clog2(`TXQ_BLOCK_DEPTH)-1:0] waddr_t;

endpackage

`default_nettype wire

/* txq_read_mux.sv */
/*
 * Read-out stage. Follows the read strobe by one cycle to pick the
 * bank pair of the group being read, then registers data, metadata,
 * package info and lane index together with the valid flag.
 */
`timescale 1ns/1ps
`default_nettype none

`include "txq_defines.svh"

module txq_read_mux
    import txq_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_reset,
    txq_rd_if.mux        rd,
    input  wire [3:0]    i_lane_idx,
    input  wire sample_t i_data0,
    input  wire sample_t i_data1,
    input  wire meta_t   i_meta0,
    input  wire meta_t   i_meta1,
    output logic         o_vld,
    output sample_t      o_data,
    output meta_t        o_meta,
    output pkg_info_t    o_pkg_info,
    output logic [2:0]   o_lane_idx
);

    logic      ren_d;
    logic      grp_d;
    logic [3:0] grp_idx;
    pkg_info_t pkg_info_d;

    // Bank data shows up one cycle after the strobe
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ren_d <= 1'b0;
            o_vld <= 1'b0;
        end else begin
            ren_d <= rd.ren;
            o_vld <= ren_d;
        end
    end

    always_ff @(posedge i_clk) begin
        grp_d <= rd.grp;
    end

    // Upper nibble group number, lower nibble antenna number
    always_comb begin
        grp_idx = 4'(i_lane_idx << 1) + 4'(grp_d);
        for (int k = 0; k < `TXQ_GRP_ANT; k++) begin
            pkg_info_d[k] = {grp_idx, 4'(i_lane_idx << 3) + 4'(2 * k) + 4'(grp_d)};
        end
    end

    always_ff @(posedge i_clk) begin
        o_data     <= grp_d ? i_data1 : i_data0;
        o_meta     <= grp_d ? i_meta1 : i_meta0;
        o_pkg_info <= pkg_info_d;
        // Antennas 0-7 on lane 0, anything above counts as lane 1
        o_lane_idx <= (i_lane_idx == 4'd0) ? 3'd0 : 3'd1;
    end

endmodule

`default_nettype wire

/* txq_top.sv */
/*
 * Transmit antenna data queue. Writes eight-antenna elements into
 * per-group ping-pong blocks and plays each full block out as group 0
 * then group 1, framed into resource blocks with PRB numbering.
 * The source may strobe i_rx_vld only while o_tready is high.
 */
`timescale 1ns/1ps
`default_nettype none

`include "txq_defines.svh"

module txq_top
    import txq_pkg::*;
(
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire [`TXQ_NUM_ANT-1:0][31:0] i_ant_data,
    input  wire [`TXQ_NUM_ANT-1:0][7:0]  i_fft_agc,
    input  wire                          i_rx_vld,
    input  wire [3:0]                    i_lane_idx,
    input  wire [3:0]                    i_rbg_idx,
    input  wire [3:0]                    i_pkg_type,
    input  wire                          i_cell_idx,
    input  wire [6:0]                    i_slot_idx,
    input  wire [3:0]                    i_symb_idx,
    output logic [`TXQ_GRP_ANT-1:0][31:0] o_tx_data,
    output logic                         o_tx_vld,
    output logic                         o_tx_sop,
    output logic                         o_tx_eop,
    output logic                         o_tready,
    output logic [8:0]                   o_prb_idx,
    output logic [`TXQ_GRP_ANT-1:0][7:0] o_pkg_info,
    output logic [2:0]                   o_lane_idx,
    output logic [31:0]                  o_fft_agc,
    output logic [3:0]                   o_rbg_idx,
    output logic [3:0]                   o_pkg_type,
    output logic                         o_cell_idx,
    output logic [6:0]                   o_slot_idx,
    output logic [3:0]                   o_symb_idx
);

    txq_wr_if wr_if ();
    txq_rd_if rd_if ();

    sample_t bank_data [2];
    meta_t   bank_meta [2];
    meta_t   tx_meta;

    txq_packer txq_packer_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_vld   (i_rx_vld),
        .i_ant_data (i_ant_data),
        .i_fft_agc  (i_fft_agc),
        .i_rbg_idx  (i_rbg_idx),
        .i_pkg_type (i_pkg_type),
        .i_cell_idx (i_cell_idx),
        .i_slot_idx (i_slot_idx),
        .i_symb_idx (i_symb_idx),
        .wr         (wr_if)
    );

    txq_ctrl txq_ctrl_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .wr       (wr_if),
        .rd       (rd_if),
        .o_tready (o_tready)
    );

    // One sample bank and one metadata bank per antenna group
    for (genvar g = 0; g < 2; g++) begin : gen_grp
        txq_bank #(
            .PAYLOAD_T (sample_t)
        ) data_bank_inst (
            .i_clk     (i_clk),
            .wr        (wr_if),
            .rd        (rd_if),
            .i_grp     (1'(g)),
            .o_rd_data (bank_data[g])
        );

        txq_bank #(
            .PAYLOAD_T (meta_t)
        ) meta_bank_inst (
            .i_clk     (i_clk),
            .wr        (wr_if),
            .rd        (rd_if),
            .i_grp     (1'(g)),
            .o_rd_data (bank_meta[g])
        );
    end

    txq_read_mux txq_read_mux_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .rd         (rd_if),
        .i_lane_idx (i_lane_idx),
        .i_data0    (bank_data[0]),
        .i_data1    (bank_data[1]),
        .i_meta0    (bank_meta[0]),
        .i_meta1    (bank_meta[1]),
        .o_vld      (o_tx_vld),
        .o_data     (o_tx_data),
        .o_meta     (tx_meta),
        .o_pkg_info (o_pkg_info),
        .o_lane_idx (o_lane_idx)
    );

    txq_framer txq_framer_inst (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_vld     (o_tx_vld),
        .o_sop     (o_tx_sop),
        .o_eop     (o_tx_eop),
        .o_prb_idx (o_prb_idx)
    );

    // Metadata fields out to their own ports
    assign o_fft_agc  = tx_meta.fft_agc;
    assign o_rbg_idx  = tx_meta.rbg_idx;
    assign o_pkg_type = tx_meta.pkg_type;
    assign o_cell_idx = tx_meta.cell_idx;
    assign o_slot_idx = tx_meta.slot_idx;
    assign o_symb_idx = tx_meta.symb_idx;

endmodule

`default_nettype wire
